// File: src/fma_cfg.svh
`ifndef FMA_CFG_SVH
`define FMA_CFG_SVH

// single precision field widths
`define FMA_EXP_W 8
`define FMA_MAN_W 23

// exponent bias of the stored field
`define FMA_EXP_BIAS 127

// every NaN result uses this quiet pattern
`define FMA_QNAN 32'h7fc0_0000

// invalid, div_zero, overflow, underflow, inexact
`define FMA_FLAG_W 5

`endif

// File: src/fma_pkg.sv
`include "fma_cfg.svh"

package fma_pkg;

  // sign, biased exponent, stored mantissa
  typedef logic [`FMA_EXP_W+`FMA_MAN_W:0] fp_word_t;

  // codes 5 to 7 round like RNE
  typedef enum logic [2:0] {
    RNE = 3'd0,
    RTZ = 3'd1,
    RDN = 3'd2,
    RUP = 3'd3,
    RMM = 3'd4
  } rnd_mode_e;

  // bit 0 negates c, bit 1 negates the product
  typedef enum logic [1:0] {
    MADD  = 2'd0,
    MSUB  = 2'd1,
    NMADD = 2'd2,
    NMSUB = 2'd3
  } fma_op_e;

  typedef enum logic [2:0] {
    ZERO,
    SUB,
    NORM,
    INF,
    NAN
  } fp_class_e;

  typedef struct packed {
    logic invalid;
    logic div_zero;
    logic overflow;
    logic underflow;
    logic inexact;
  } fp_flags_t;

endpackage

// File: src/fp_classify.sv
`timescale 1ns/1ps
`include "fma_cfg.svh"

module fp_classify (
  input  fma_pkg::fp_word_t  word,
  output logic               sign,
  output logic [9:0]         exp,
  output logic [23:0]        man,
  output fma_pkg::fp_class_e cls
);
  import fma_pkg::*;

  logic [`FMA_EXP_W-1:0] e_fld;
  logic [`FMA_MAN_W-1:0] m_fld;
  logic                  e_zero;
  logic                  e_ones;

  assign sign   = word[`FMA_EXP_W+`FMA_MAN_W];
  assign e_fld  = word[`FMA_EXP_W+`FMA_MAN_W-1:`FMA_MAN_W];
  assign m_fld  = word[`FMA_MAN_W-1:0];
  assign e_zero = (e_fld == '0);
  assign e_ones = (e_fld == '1);

  // subnormals and zero sit at the minimum exponent with no hidden bit
  assign exp = e_zero ? 10'(1 - `FMA_EXP_BIAS) : {2'b00, e_fld} - 10'(`FMA_EXP_BIAS);
  assign man = {~e_zero, m_fld};

  always_comb begin
    if (e_ones) begin
      cls = (m_fld != '0) ? NAN : INF;
    end else if (e_zero) begin
      cls = (m_fld != '0) ? SUB : ZERO;
    end else begin
      cls = NORM;
    end
  end

endmodule

// File: src/fp_round.sv
`timescale 1ns/1ps

module fp_round (
  input  logic [23:0]        man_in,
  input  logic [9:0]         exp_in,
  input  logic               sign,
  input  logic               guard,
  input  logic               round_bit,
  input  logic               sticky,
  input  fma_pkg::rnd_mode_e rm,
  output logic [23:0]        man_out,
  output logic [9:0]         exp_out,
  output logic               inexact
);
  import fma_pkg::*;

  logic        lost;
  logic        inc;
  logic [24:0] sum;

  // any nonzero discarded bit
  assign lost = guard | round_bit | sticky;

  always_comb begin
    case (rm)
      RTZ: inc = 1'b0;
      RDN: inc = sign & lost;
      RUP: inc = ~sign & lost;
      // ties away from zero
      RMM: inc = guard;
      // ties to even, also for unused codes
      default: inc = guard & (round_bit | sticky | man_in[0]);
    endcase
  end

  assign sum = {1'b0, man_in} + {24'd0, inc};

  always_comb begin
    if (sum[24]) begin
      // carry out, mantissa is 1.000.. again one binade up
      man_out = sum[24:1];
      exp_out = exp_in + 10'd1;
    end else begin
      // a subnormal that rounds into bit 23 becomes the smallest normal
      man_out = sum[23:0];
      exp_out = exp_in;
    end
  end

  assign inexact = lost;

endmodule

// File: src/fma_datapath.sv
`timescale 1ns/1ps
`include "fma_cfg.svh"

module fma_datapath (
  input  logic               clk,
  input  logic               rst,
  input  fma_pkg::fma_op_e   op,
  input  fma_pkg::rnd_mode_e rm,
  input  logic               a_sign,
  input  logic [9:0]         a_exp,
  input  logic [23:0]        a_man,
  input  fma_pkg::fp_class_e a_cls,
  input  logic               b_sign,
  input  logic [9:0]         b_exp,
  input  logic [23:0]        b_man,
  input  fma_pkg::fp_class_e b_cls,
  input  logic               c_sign,
  input  logic [9:0]         c_exp,
  input  logic [23:0]        c_man,
  input  fma_pkg::fp_class_e c_cls,
  input  logic [23:0]        rnd_man,
  input  logic [9:0]         rnd_exp,
  input  logic               rnd_inexact,
  output logic [23:0]        norm_man,
  output logic [9:0]         norm_exp,
  output logic               norm_sign,
  output logic               guard,
  output logic               round_bit,
  output logic               sticky,
  output fma_pkg::fp_word_t  z,
  output logic               z_stb,
  output fma_pkg::fp_flags_t flags
);
  import fma_pkg::*;

  localparam logic signed [9:0] EMIN = 10'(1 - `FMA_EXP_BIAS);
  localparam logic signed [9:0] EMAX = 10'(`FMA_EXP_BIAS);

  typedef enum logic [3:0] {
    S_SAMPLE, S_SPECIAL, S_PRENORM, S_MULT, S_ALIGN,
    S_ADD, S_NORM, S_DENORM, S_PACK, S_OUT
  } state_e;

  state_e    state;
  fma_op_e   op_r;
  rnd_mode_e rm_r;
  fp_class_e a_k, b_k, c_k;

  logic               a_s, b_s, c_s;
  logic signed [9:0]  a_e, b_e, c_e, t_e, ze;
  logic [23:0]        a_m, b_m, c_m;
  // both terms share one frame, msb at bit 49, bit 0 collects sticky
  logic [50:0]        t_m, u_m, s_r;
  logic               z_s, tiny;
  fp_word_t           z_r, pk_word;
  fp_flags_t          f_r;
  logic [`FMA_FLAG_W-1:0] pk_flags;

  logic              ps, cs;
  logic              any_nan, prod_inf, prod_zero, c_inf, c_zero, inf_x_zero;
  logic              zero_sign, ovf, to_max;
  logic [47:0]       prod;
  logic signed [9:0] d, def;
  logic [`FMA_EXP_W-1:0] c_fld;

  // right shift that folds the lost bits into bit 0
  function automatic logic [50:0] shr_st(input logic [50:0] x, input int unsigned n);
    logic [50:0] lost;
    lost = x & ((51'd1 << n) - 51'd1);
    return (x >> n) | {50'd0, |lost};
  endfunction

  // effective signs of the product and of the addend
  assign ps = a_s ^ b_s ^ op_r[1];
  assign cs = c_s ^ op_r[0];

  assign any_nan    = (a_k == NAN) || (b_k == NAN) || (c_k == NAN);
  assign prod_inf   = (a_k == INF) || (b_k == INF);
  assign prod_zero  = (a_k == ZERO) || (b_k == ZERO);
  assign inf_x_zero = prod_inf && prod_zero;
  assign c_inf      = (c_k == INF);
  assign c_zero     = (c_k == ZERO);
  assign zero_sign  = (ps & cs) | ((ps ^ cs) & (rm_r == RDN));
  assign c_fld      = c_m[23] ? c_e[7:0] + 8'(`FMA_EXP_BIAS) : '0;

  assign prod = a_m * b_m;
  assign d    = t_e - c_e;
  assign def  = EMIN - ze;

  assign norm_man  = s_r[50:27];
  assign guard     = s_r[26];
  assign round_bit = s_r[25];
  assign sticky    = |s_r[24:0];
  assign norm_exp  = ze;
  assign norm_sign = z_s;

  always_comb begin
    ovf    = $signed(rnd_exp) > EMAX;
    // modes that never round away from zero for this sign
    to_max = (rm_r == RTZ) || ((rm_r == RDN) && !z_s) || ((rm_r == RUP) && z_s);
    if (ovf && to_max) begin
      pk_word = {z_s, {(`FMA_EXP_W-1){1'b1}}, 1'b0, {`FMA_MAN_W{1'b1}}};
    end else if (ovf) begin
      pk_word = {z_s, {`FMA_EXP_W{1'b1}}, {`FMA_MAN_W{1'b0}}};
    end else begin
      pk_word = {z_s, rnd_man[23] ? rnd_exp[7:0] + 8'(`FMA_EXP_BIAS) : 8'd0,
                 rnd_man[22:0]};
    end
    pk_flags = {1'b0, 1'b0, ovf, tiny & rnd_inexact, ovf | rnd_inexact};
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= S_SAMPLE;
      z_stb <= 1'b0;
    end else begin
      case (state)
        S_SAMPLE: begin
          z_stb <= 1'b0;
          op_r  <= op;
          rm_r  <= rm;
          a_s   <= a_sign;
          a_e   <= a_exp;
          a_m   <= a_man;
          a_k   <= a_cls;
          b_s   <= b_sign;
          b_e   <= b_exp;
          b_m   <= b_man;
          b_k   <= b_cls;
          c_s   <= c_sign;
          c_e   <= c_exp;
          c_m   <= c_man;
          c_k   <= c_cls;
          state <= S_SPECIAL;
        end
        S_SPECIAL: begin
          state <= S_OUT;
          f_r   <= '0;
          if (any_nan || inf_x_zero || (prod_inf && c_inf && (ps != cs))) begin
            z_r         <= `FMA_QNAN;
            f_r.invalid <= 1'b1;
          end else if (prod_inf) begin
            z_r <= {ps, {`FMA_EXP_W{1'b1}}, {`FMA_MAN_W{1'b0}}};
          end else if (c_inf) begin
            z_r <= {cs, {`FMA_EXP_W{1'b1}}, {`FMA_MAN_W{1'b0}}};
          end else if (prod_zero && c_zero) begin
            z_r <= {zero_sign, 31'd0};
          end else if (prod_zero) begin
            z_r <= {cs, c_fld, c_m[22:0]};
          end else begin
            state <= S_PRENORM;
          end
        end
        S_PRENORM: begin
          // subnormal inputs move up to a leading one
          if (!a_m[23]) begin
            a_m <= a_m << 1;
            a_e <= a_e - 10'sd1;
          end
          if (!b_m[23]) begin
            b_m <= b_m << 1;
            b_e <= b_e - 10'sd1;
          end
          if (!c_m[23] && !c_zero) begin
            c_m <= c_m << 1;
            c_e <= c_e - 10'sd1;
          end
          if (a_m[23] && b_m[23] && (c_m[23] || c_zero)) begin
            state <= S_MULT;
          end
        end
        S_MULT: begin
          if (prod[47]) begin
            t_m <= {1'b0, prod, 2'b00};
            t_e <= a_e + b_e + 10'sd1;
          end else begin
            t_m <= {1'b0, prod[46:0], 3'b000};
            t_e <= a_e + b_e;
          end
          u_m   <= {1'b0, c_m, 26'd0};
          state <= S_ALIGN;
        end
        S_ALIGN: begin
          // far out of range the smaller term only survives as sticky
          if (c_zero || (d == 10'sd0)) begin
            state <= S_ADD;
          end else if (d > 10'sd50) begin
            u_m <= {50'd0, |u_m};
            c_e <= t_e;
          end else if (d >= 10'sd8) begin
            u_m <= shr_st(u_m, 8);
            c_e <= c_e + 10'sd8;
          end else if (d > 10'sd0) begin
            u_m <= shr_st(u_m, 1);
            c_e <= c_e + 10'sd1;
          end else if (d < -10'sd50) begin
            t_m <= {50'd0, |t_m};
            t_e <= c_e;
          end else if (d <= -10'sd8) begin
            t_m <= shr_st(t_m, 8);
            t_e <= t_e + 10'sd8;
          end else begin
            t_m <= shr_st(t_m, 1);
            t_e <= t_e + 10'sd1;
          end
        end
        S_ADD: begin
          // bit 50 of the sum weighs one binade above the frame msb
          ze <= t_e + 10'sd1;
          if (ps == cs) begin
            s_r <= t_m + u_m;
            z_s <= ps;
          end else if (t_m >= u_m) begin
            s_r <= t_m - u_m;
            z_s <= ps;
          end else begin
            s_r <= u_m - t_m;
            z_s <= cs;
          end
          state <= S_NORM;
        end
        S_NORM: begin
          if (s_r == '0) begin
            z_r   <= {rm_r == RDN, 31'd0};
            f_r   <= '0;
            state <= S_OUT;
          end else if (s_r[50:43] == 8'd0) begin
            s_r <= s_r << 8;
            ze  <= ze - 10'sd8;
          end else if (!s_r[50]) begin
            s_r <= s_r << 1;
            ze  <= ze - 10'sd1;
          end else begin
            tiny  <= (ze < EMIN);
            state <= S_DENORM;
          end
        end
        S_DENORM: begin
          if (def > 10'sd51) begin
            s_r <= {50'd0, |s_r};
            ze  <= EMIN;
          end else if (def >= 10'sd8) begin
            s_r <= shr_st(s_r, 8);
            ze  <= ze + 10'sd8;
          end else if (def > 10'sd0) begin
            s_r <= shr_st(s_r, 1);
            ze  <= ze + 10'sd1;
          end else begin
            state <= S_PACK;
          end
        end
        S_PACK: begin
          z_r   <= pk_word;
          f_r   <= fp_flags_t'(pk_flags);
          state <= S_OUT;
        end
        S_OUT: begin
          z     <= z_r;
          flags <= f_r;
          z_stb <= 1'b1;
          state <= S_SAMPLE;
        end
        default: state <= S_SAMPLE;
      endcase
    end
  end

endmodule

// File: src/fma_unit.sv
`timescale 1ns/1ps

module fma_unit (
  input  logic               clk,
  input  logic               rst,
  input  fma_pkg::fp_word_t  a,
  input  fma_pkg::fp_word_t  b,
  input  fma_pkg::fp_word_t  c,
  input  fma_pkg::fma_op_e   op,
  input  fma_pkg::rnd_mode_e rm,
  output fma_pkg::fp_word_t  z,
  output logic               z_stb,
  output fma_pkg::fp_flags_t flags
);
  import fma_pkg::*;

  logic        a_sign, b_sign, c_sign;
  logic [9:0]  a_exp, b_exp, c_exp;
  logic [23:0] a_man, b_man, c_man;
  fp_class_e   a_cls, b_cls, c_cls;

  logic [23:0] norm_man, rnd_man;
  logic [9:0]  norm_exp, rnd_exp;
  logic        norm_sign, guard, round_bit, sticky, rnd_inexact;

  fp_classify u_cls_a (.word(a), .sign(a_sign), .exp(a_exp), .man(a_man), .cls(a_cls));
  fp_classify u_cls_b (.word(b), .sign(b_sign), .exp(b_exp), .man(b_man), .cls(b_cls));
  fp_classify u_cls_c (.word(c), .sign(c_sign), .exp(c_exp), .man(c_man), .cls(c_cls));

  fma_datapath u_datapath (
    .clk(clk), .rst(rst), .op(op), .rm(rm),
    .a_sign(a_sign), .a_exp(a_exp), .a_man(a_man), .a_cls(a_cls),
    .b_sign(b_sign), .b_exp(b_exp), .b_man(b_man), .b_cls(b_cls),
    .c_sign(c_sign), .c_exp(c_exp), .c_man(c_man), .c_cls(c_cls),
    .rnd_man(rnd_man), .rnd_exp(rnd_exp), .rnd_inexact(rnd_inexact),
    .norm_man(norm_man), .norm_exp(norm_exp), .norm_sign(norm_sign),
    .guard(guard), .round_bit(round_bit), .sticky(sticky),
    .z(z), .z_stb(z_stb), .flags(flags)
  );

  // rm is held stable by the environment until the strobe
  fp_round u_round (
    .man_in(norm_man), .exp_in(norm_exp), .sign(norm_sign),
    .guard(guard), .round_bit(round_bit), .sticky(sticky), .rm(rm),
    .man_out(rnd_man), .exp_out(rnd_exp), .inexact(rnd_inexact)
  );

endmodule

// File: verif/fma_props.sv
`timescale 1ns/1ps
`include "fma_cfg.svh"

module fma_props (
  input logic               clk,
  input logic               rst,
  input fma_pkg::fp_word_t  z,
  input logic               z_stb,
  input fma_pkg::fp_flags_t flags
);

  // the result strobe is a single-cycle pulse
  a_stb_pulse: assert property (@(posedge clk) disable iff (rst) z_stb |=> !z_stb)
    else $error("z_stb stayed high for two cycles");

  // no strobe leaks out right after reset
  a_stb_after_rst: assert property (@(posedge clk) rst |=> !z_stb)
    else $error("z_stb high in the cycle after reset");

  // an invalid operation always returns the canonical quiet NaN
  a_invalid_qnan: assert property (@(posedge clk) disable iff (rst)
    (z_stb && flags.invalid) |-> (z == `FMA_QNAN))
    else $error("invalid result is not the canonical quiet NaN");

endmodule

bind fma_unit fma_props u_props (
  .clk(clk),
  .rst(rst),
  .z(z),
  .z_stb(z_stb),
  .flags(flags)
);

// File: verif/fma_tb.sv
`timescale 1ns/1ps
`include "fma_cfg.svh"

module fma_tb;
  import fma_pkg::*;

  localparam int WW = 512;
  localparam int TIMEOUT = 200;

  logic      clk;
  logic      rst;
  fp_word_t  a, b, c, z;
  fma_op_e   op;
  rnd_mode_e rm;
  logic      z_stb;
  fp_flags_t flags;

  logic [31:0] lcg_state;
  int          word_errs;
  int          flag_errs;
  int          other_errs;
  fp_word_t    exp_w_q[$];
  fp_flags_t   exp_f_q[$];

  fma_unit DUT (
    .clk(clk), .rst(rst), .a(a), .b(b), .c(c), .op(op), .rm(rm),
    .z(z), .z_stb(z_stb), .flags(flags)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // random normal word with its biased exponent in lo..hi
  function automatic fp_word_t rand_norm(input int lo, input int hi);
    logic [31:0] r;
    int          e;
    r = lcg_next();
    e = lo + int'(r[30:23]) % (hi - lo + 1);
    return {r[31], 8'(e), r[22:0]};
  endfunction

  // random subnormal word, zero when the mantissa bits happen to be clear
  function automatic fp_word_t rand_sub();
    logic [31:0] r;
    r = lcg_next();
    return {r[31], 8'd0, r[30:8]};
  endfunction

  function automatic logic is_nan(input fp_word_t x);
    return (x[30:23] == 8'hff) && (x[22:0] != 23'd0);
  endfunction

  function automatic logic is_inf(input fp_word_t x);
    return (x[30:23] == 8'hff) && (x[22:0] == 23'd0);
  endfunction

  function automatic logic is_zero(input fp_word_t x);
    return x[30:0] == 31'd0;
  endfunction

  // integer significand, hidden bit included for normals
  function automatic logic [23:0] man_of(input fp_word_t x);
    return {x[30:23] != 8'd0, x[22:0]};
  endfunction

  // weight of the significand lsb as a power of two
  function automatic int lsb_exp(input fp_word_t x);
    return ((x[30:23] == 8'd0) ? 1 : int'(x[30:23])) - 150;
  endfunction

  // expected word and flags, exact value first and one rounding at the end
  function automatic void fma_ref(input fp_word_t fa, input fp_word_t fb, input fp_word_t fc,
                                  input fma_op_e fop, input rnd_mode_e frm,
                                  output fp_word_t w, output fp_flags_t f);
    logic [1:0]    opb;
    logic          ps, cs, zs, p_inf, p_zero, c_inf, c_zero, any_nan;
    logic          g, rest_nz, lost, inc, tiny, to_max;
    logic [47:0]   pr;
    logic [WW-1:0] pv, cv, r, keep;
    int            xp, xc, base, msb, e, ee, sh;
    opb = fop;
    ps = fa[31] ^ fb[31] ^ opb[1];
    cs = fc[31] ^ opb[0];
    any_nan = is_nan(fa) || is_nan(fb) || is_nan(fc);
    p_inf = is_inf(fa) || is_inf(fb);
    p_zero = is_zero(fa) || is_zero(fb);
    c_inf = is_inf(fc);
    c_zero = is_zero(fc);
    f = '0;
    w = '0;
    if (any_nan || (p_inf && p_zero) || (p_inf && c_inf && (ps != cs))) begin
      w = `FMA_QNAN;
      f.invalid = 1'b1;
      return;
    end
    if (p_inf || c_inf) begin
      w = {p_inf ? ps : cs, 8'hff, 23'd0};
      return;
    end
    if (p_zero) begin
      if (c_zero) begin
        zs = (ps & cs) | ((ps ^ cs) & (frm == RDN));
        w = {zs, 31'd0};
      end else begin
        w = {cs, fc[30:0]};
      end
      return;
    end
    pr = man_of(fa) * man_of(fb);
    xp = lsb_exp(fa) + lsb_exp(fb);
    xc = lsb_exp(fc);
    base = (xp < xc) ? xp : xc;
    pv = WW'(pr) << (xp - base);
    cv = WW'(man_of(fc)) << (xc - base);
    if (ps == cs) begin
      r = pv + cv;
      zs = ps;
    end else if (pv >= cv) begin
      r = pv - cv;
      zs = ps;
    end else begin
      r = cv - pv;
      zs = cs;
    end
    if (r == '0) begin
      w = {frm == RDN, 31'd0};
      return;
    end
    msb = 0;
    for (int i = 0; i < WW; i++) begin
      if (r[i]) msb = i;
    end
    e = msb + base;
    tiny = e < -126;
    ee = tiny ? -126 : e;
    sh = ee - 23 - base;
    if (sh <= 0) begin
      keep = r << (-sh);
      g = 1'b0;
      rest_nz = 1'b0;
    end else begin
      keep = r >> sh;
      g = r[sh-1];
      rest_nz = (r & ((WW'(1) << (sh - 1)) - WW'(1))) != '0;
    end
    lost = g | rest_nz;
    case (frm)
      RTZ: inc = 1'b0;
      RDN: inc = zs & lost;
      RUP: inc = ~zs & lost;
      RMM: inc = g;
      default: inc = g & (rest_nz | keep[0]);
    endcase
    keep = keep + WW'(inc);
    if (keep[24]) begin
      keep = keep >> 1;
      ee = ee + 1;
    end
    if (ee > 127) begin
      to_max = (frm == RTZ) || ((frm == RDN) && !zs) || ((frm == RUP) && zs);
      w = to_max ? {zs, 8'hfe, 23'h7fffff} : {zs, 8'hff, 23'd0};
      f.overflow = 1'b1;
      f.inexact = 1'b1;
      return;
    end
    w = {zs, keep[23] ? 8'(ee + 127) : 8'd0, keep[22:0]};
    f.underflow = tiny & lost;
    f.inexact = lost;
  endfunction

  task automatic check_word(input string name, input fp_word_t got, input fp_word_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      word_errs++;
    end
  endtask

  task automatic check_flags(input string name, input fp_flags_t got, input fp_flags_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      flag_errs++;
    end
  endtask

  // compares every strobe against the oldest pending expectation
  always @(negedge clk) begin
    if (!rst && z_stb) begin
      if (exp_w_q.size() == 0) begin
        $display("result strobe arrived with no operation pending");
        other_errs++;
      end else begin
        check_word("z", z, exp_w_q.pop_front());
        check_flags("flags", flags, exp_f_q.pop_front());
      end
    end
  end

  task automatic end_run();
    $display("errors: word %0d, flags %0d, other %0d", word_errs, flag_errs, other_errs);
    if (word_errs + flag_errs + other_errs == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  endtask

  task automatic wait_strobe();
    int n;
    n = 0;
    @(negedge clk);
    while (!z_stb && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!z_stb) begin
      $display("timeout, no result strobe within %0d cycles", TIMEOUT);
      other_errs++;
      end_run();
    end
  endtask

  task automatic drive_op(input fp_word_t ia, input fp_word_t ib, input fp_word_t ic,
                          input fma_op_e iop, input rnd_mode_e irm);
    a = ia;
    b = ib;
    c = ic;
    op = iop;
    rm = irm;
  endtask

  // expectation from the inputs that the DUT is sampling now
  task automatic finish_op();
    fp_word_t  w;
    fp_flags_t f;
    fma_ref(a, b, c, op, rm, w, f);
    exp_w_q.push_back(w);
    exp_f_q.push_back(f);
    wait_strobe();
  endtask

  task automatic run_op(input fp_word_t ia, input fp_word_t ib, input fp_word_t ic,
                        input fma_op_e iop, input rnd_mode_e irm);
    drive_op(ia, ib, ic, iop, irm);
    finish_op();
  endtask

  task automatic reset_dut();
    rst = 1'b1;
    repeat (3) @(negedge clk);
    exp_w_q.delete();
    exp_f_q.delete();
    rst = 1'b0;
    @(negedge clk);
    if (z_stb !== 1'b0) begin
      $display("result strobe not low in the cycle after reset");
      other_errs++;
    end
  endtask

  initial begin
    int lo;
    int hi;
    clk = 1'b0;
    rst = 1'b1;
    lcg_state = 32'h68775bf8;
    word_errs = 0;
    flag_errs = 0;
    other_errs = 0;
    drive_op(32'h3f800000, 32'h3f800000, 32'h00000000, MADD, RNE);
    reset_dut();
    finish_op();

    // small integers, exact under every operation
    for (int k = 0; k < 4; k++) begin
      run_op(32'h40000000, 32'h40400000, 32'h3f800000, fma_op_e'(k), RNE);
      run_op(32'hc0a00000, 32'h40e00000, 32'h41200000, fma_op_e'(k), RTZ);
    end

    // special cases
    run_op(32'h7fc00000, 32'h3f800000, 32'h3f800000, MADD, RNE);
    run_op(32'h3f800000, 32'h3f800000, 32'hff800001, MADD, RNE);
    run_op(32'h7f800000, 32'h00000000, 32'h3f800000, MADD, RNE);
    run_op(32'h7f800000, 32'h3f800000, 32'h7f800000, MSUB, RNE);
    run_op(32'h7f800000, 32'hbf800000, 32'h7f800000, NMADD, RUP);
    run_op(32'h40000000, 32'h40000000, 32'hff800000, MADD, RNE);
    run_op(32'h00000000, 32'h40a00000, 32'h40600000, NMSUB, RNE);
    run_op(32'h00000000, 32'h3f800000, 32'h80000000, MADD, RNE);
    run_op(32'h00000000, 32'h3f800000, 32'h80000000, MADD, RDN);
    run_op(32'h80000000, 32'h3f800000, 32'h80000000, MADD, RUP);
    run_op(32'h3f800000, 32'h3f800000, 32'h3f800000, MSUB, RNE);
    run_op(32'h3f800000, 32'h3f800000, 32'h3f800000, MSUB, RDN);

    // overflow under every mode
    for (int m = 0; m < 5; m++) begin
      run_op(32'h7f000000, 32'h7f000000, 32'h00000000, MADD, rnd_mode_e'(m));
      run_op(32'hff000000, 32'h7f000000, 32'h3f800000, MADD, rnd_mode_e'(m));
      run_op(32'h7f7fffff, 32'h3f800001, 32'h7f7fffff, MADD, rnd_mode_e'(m));
    end

    // tiny results and subnormal inputs
    run_op(32'h00800000, 32'h3e800000, 32'h00000000, MADD, RNE);
    for (int m = 0; m < 5; m++) begin
      run_op(32'h00800001, 32'h3f7fffff, 32'h00000000, MADD, rnd_mode_e'(m));
      run_op(32'h00000005, 32'h3f000000, 32'h80000001, MSUB, rnd_mode_e'(m));
    end
    run_op(32'h00000003, 32'h40400000, 32'h00000001, MADD, RNE);
    for (int i = 0; i < 40; i++) begin
      drive_op(rand_sub(), rand_norm(100, 154), rand_sub(), fma_op_e'(i % 4),
               rnd_mode_e'((i / 4) % 5));
      finish_op();
    end

    // random normals, modes cycled per operation
    for (int i = 0; i < 240; i++) begin
      lo = (i % 3 == 0) ? 100 : ((i % 3 == 1) ? 40 : 1);
      hi = 255 - lo;
      drive_op(rand_norm(lo, hi), rand_norm(lo, hi), rand_norm(1, 254),
               fma_op_e'(i % 4), rnd_mode_e'((i / 4) % 5));
      finish_op();
    end

    // reset in the middle of a long operation, a different one is sampled after it
    drive_op(32'h00000001, 32'h00000003, 32'h3f800000, NMADD, RUP);
    repeat (4) @(negedge clk);
    drive_op(32'h40400000, 32'h40400000, 32'hbf800000, MADD, RNE);
    reset_dut();
    finish_op();
    run_op(32'h00000001, 32'h00000003, 32'h3f800000, NMADD, RUP);

    @(negedge clk);
    if (exp_w_q.size() != 0) begin
      $display("%0d results never arrived", exp_w_q.size());
      other_errs++;
    end
    end_run();
  end

endmodule

// File: filelist.f
+incdir+src
src/fma_pkg.sv
src/fp_classify.sv
src/fp_round.sv
src/fma_datapath.sv
src/fma_unit.sv
verif/fma_props.sv
verif/fma_tb.sv

// File: Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert --top-module fma_tb -f filelist.f -o Vfma_tb

run: build
	./obj_dir/Vfma_tb > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "tests failed" sim.log; then exit 1; fi
	@grep -q "all tests passed" sim.log

lint:
	verilator --lint-only --timing --assert --top-module fma_tb -f filelist.f

clean:
	rm -rf obj_dir sim.log
